//--- hw/data_ram.sv
`timescale 1ns/1ns

module data_ram (
  input  logic         clk,
  mem_bus_if.responder bus
);

  logic [exu_pkg::xlen-1:0]             mem [exu_pkg::ram_words];
  logic [exu_pkg::xlen-1:0]             rdata_q;
  logic [$clog2(exu_pkg::ram_words)-1:0] idx;
  logic                                 busy_q;

  assign idx = bus.addr[$clog2(exu_pkg::ram_words)-1:0];

  // set for the one cycle that answers a request
  always_ff @(posedge clk) begin
    busy_q <= bus.req && !busy_q;
  end

  always_ff @(posedge clk) begin
    if (bus.req && !busy_q) begin
      if (bus.we) mem[idx] <= bus.wdata;
      rdata_q <= mem[idx];
    end
  end

  assign bus.done  = busy_q;
  assign bus.rdata = rdata_q;

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/1ns

module exu_alu (
  input  logic [exu_pkg::xlen-1:0] a_i,
  input  logic [exu_pkg::xlen-1:0] b_i,
  input  logic [3:0]               op_i,
  output logic [exu_pkg::xlen-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      exu_pkg::alu_add:  res_o = a_i + b_i;
      exu_pkg::alu_sub:  res_o = a_i - b_i;
      exu_pkg::alu_and:  res_o = a_i & b_i;
      exu_pkg::alu_or:   res_o = a_i | b_i;
      exu_pkg::alu_xor:  res_o = a_i ^ b_i;
      exu_pkg::alu_slt:  res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
      exu_pkg::alu_sltu: res_o = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
      exu_pkg::alu_sll:  res_o = a_i << shamt;
      exu_pkg::alu_srl:  res_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      exu_pkg::alu_sra:  res_o = $unsigned($signed(a_i) >>> shamt);
      default:           res_o = '0;
    endcase
  end

endmodule

//--- hw/exu_core.sv
`timescale 1ns/1ns

module exu_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic [6:0]               opcode_i,
  input  logic [3:0]               alu_op_i,
  input  logic [exu_pkg::xlen-1:0] op1_i,
  input  logic [exu_pkg::xlen-1:0] op2_i,
  input  logic [exu_pkg::xlen-1:0] op_j_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [4:0]               rd_i,
  input  exu_pkg::imm_word_u       imm_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [4:0]               rd_o,
  output logic [exu_pkg::xlen-1:0] reg_wdata_o,
  output logic [exu_pkg::xlen-1:0] npc_o,
  output logic                     use_npc_o,
  output logic                     ebreak_o,
  mem_bus_if.requester             lsu
);

  logic [6:0]               opcode_q;
  logic [3:0]               alu_op_q;
  logic [exu_pkg::xlen-1:0] op1_q;
  logic [exu_pkg::xlen-1:0] op2_q;
  logic [exu_pkg::xlen-1:0] op_j_q;
  logic [exu_pkg::xlen-1:0] pc_q;
  logic [exu_pkg::xlen-1:0] lsu_addr_q;
  logic [exu_pkg::xlen-1:0] load_q;
  logic [4:0]               rd_q;
  exu_pkg::imm_word_u       imm_q;

  logic out_valid_q;
  logic busy_q;
  logic lsu_req_q;

  logic                     accept;
  logic                     res_fire;
  logic                     in_is_mem;
  logic [exu_pkg::xlen-1:0] addr_sum;
  logic [exu_pkg::xlen-1:0] alu_res;
  logic [exu_pkg::xlen-1:0] csr_rdata;
  logic [exu_pkg::xlen-1:0] csr_wdata;
  logic [exu_pkg::xlen-1:0] mtvec;
  logic [exu_pkg::xlen-1:0] mepc;
  logic [11:0]              csr_addr;
  logic is_load, is_jump, is_sys, is_priv, is_csr;
  logic is_ecall, is_mret, is_ebreak;

  // hold a finished result until the consumer takes it
  assign in_ready_o = !busy_q && (!out_valid_q || out_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign res_fire   = out_valid_q && out_ready_i;
  assign in_is_mem  = (opcode_i == exu_pkg::op_load) || (opcode_i == exu_pkg::op_store);
  assign addr_sum   = op1_i + imm_i.val;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
      busy_q      <= 1'b0;
      lsu_req_q   <= 1'b0;
    end else begin
      if (res_fire) out_valid_q <= 1'b0;
      if (lsu.done) begin
        lsu_req_q   <= 1'b0;
        busy_q      <= 1'b0;
        out_valid_q <= 1'b1;
      end
      if (accept) begin
        if (in_is_mem) begin
          lsu_req_q <= 1'b1;
          busy_q    <= 1'b1;
        end else begin
          out_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opcode_q   <= opcode_i;
      alu_op_q   <= alu_op_i;
      op1_q      <= op1_i;
      op2_q      <= op2_i;
      op_j_q     <= op_j_i;
      pc_q       <= pc_i;
      rd_q       <= rd_i;
      imm_q      <= imm_i;
      lsu_addr_q <= {2'b00, addr_sum[exu_pkg::xlen-1:2]};
    end
    if (lsu.done) load_q <= lsu.rdata;
  end

  assign lsu.req   = lsu_req_q;
  assign lsu.we    = (opcode_q == exu_pkg::op_store);
  assign lsu.addr  = lsu_addr_q;
  assign lsu.wdata = op2_q;

  exu_alu u_alu (
    .a_i   (op1_q),
    .b_i   (op2_q),
    .op_i  (alu_op_q),
    .res_o (alu_res)
  );

  // decode of the registered op
  assign is_load   = (opcode_q == exu_pkg::op_load);
  assign is_jump   = (opcode_q == exu_pkg::op_jal) || (opcode_q == exu_pkg::op_jalr);
  assign is_sys    = (opcode_q == exu_pkg::op_system);
  assign is_priv   = is_sys && (imm_q.sys.funct3 == exu_pkg::sys_priv);
  assign is_csr    = is_sys && !is_priv;
  assign is_ecall  = is_priv && (imm_q.sys.funct12 == exu_pkg::f12_ecall);
  assign is_mret   = is_priv && (imm_q.sys.funct12 == exu_pkg::f12_mret);
  assign is_ebreak = is_priv && (imm_q.sys.funct12 == exu_pkg::f12_ebreak);

  assign csr_addr = is_mret ? exu_pkg::csr_mstatus : imm_q.sys.funct12;

  always_comb begin
    case (imm_q.sys.funct3)
      exu_pkg::sys_csrrw, exu_pkg::sys_csrrwi: csr_wdata = op1_q;
      exu_pkg::sys_csrrs, exu_pkg::sys_csrrsi: csr_wdata = csr_rdata | op1_q;
      exu_pkg::sys_csrrc, exu_pkg::sys_csrrci: csr_wdata = csr_rdata & ~op1_q;
      // mret moves mpie back to mie and sets mpie
      default: csr_wdata = {csr_rdata[exu_pkg::xlen-1:8], 1'b1, csr_rdata[6:4],
                            csr_rdata[7], csr_rdata[2:0]};
    endcase
  end

  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (res_fire && (is_csr || is_mret)),
    .ecall_i (res_fire && is_ecall),
    .addr_i  (csr_addr),
    .wdata_i (csr_wdata),
    .pc_i    (pc_q),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  assign reg_wdata_o = is_load ? load_q :
                       is_sys  ? csr_rdata :
                       is_jump ? pc_q + 32'd4 : alu_res;

  assign npc_o = is_ecall ? mtvec :
                 is_mret  ? mepc : op_j_q + imm_q.val;

  always_comb begin
    use_npc_o = 1'b0;
    if (is_jump || is_ecall || is_mret) begin
      use_npc_o = 1'b1;
    end else if (opcode_q == exu_pkg::op_branch) begin
      case (alu_op_q)
        exu_pkg::alu_sub:  use_npc_o = ~|alu_res;
        exu_pkg::alu_xor,
        exu_pkg::alu_slt,
        exu_pkg::alu_sltu: use_npc_o = |alu_res;
        default:           use_npc_o = 1'b0;
      endcase
    end
  end

  assign out_valid_o = out_valid_q;
  assign rd_o        = rd_q;
  assign ebreak_o    = is_ebreak;

endmodule

//--- hw/exu_csr.sv
`timescale 1ns/1ns

module exu_csr (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wen_i,
  input  logic                     ecall_i,
  input  logic [11:0]              addr_i,
  input  logic [exu_pkg::xlen-1:0] wdata_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  output logic [exu_pkg::xlen-1:0] rdata_o,
  output logic [exu_pkg::xlen-1:0] mtvec_o,
  output logic [exu_pkg::xlen-1:0] mepc_o
);

  logic [exu_pkg::xlen-1:0] mstatus_q;
  logic [exu_pkg::xlen-1:0] mtvec_q;
  logic [exu_pkg::xlen-1:0] mepc_q;
  logic [exu_pkg::xlen-1:0] mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (ecall_i) begin
      // trap entry
      mepc_q   <= pc_i;
      mcause_q <= exu_pkg::cause_ecall_m;
    end else if (wen_i) begin
      case (addr_i)
        exu_pkg::csr_mstatus: mstatus_q <= wdata_i;
        exu_pkg::csr_mtvec:   mtvec_q   <= wdata_i;
        exu_pkg::csr_mepc:    mepc_q    <= wdata_i;
        exu_pkg::csr_mcause:  mcause_q  <= wdata_i;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (addr_i)
      exu_pkg::csr_mstatus: rdata_o = mstatus_q;
      exu_pkg::csr_mtvec:   rdata_o = mtvec_q;
      exu_pkg::csr_mepc:    rdata_o = mepc_q;
      exu_pkg::csr_mcause:  rdata_o = mcause_q;
      default:              rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

//--- hw/exu_pkg.sv
package exu_pkg;

  localparam int xlen = 32;
  localparam int ram_words = 256;

  // major opcodes
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_alu    = 7'b0110011;

  localparam logic [3:0] alu_add  = 4'd0;
  localparam logic [3:0] alu_sub  = 4'd1;
  localparam logic [3:0] alu_and  = 4'd2;
  localparam logic [3:0] alu_or   = 4'd3;
  localparam logic [3:0] alu_xor  = 4'd4;
  localparam logic [3:0] alu_slt  = 4'd5;
  localparam logic [3:0] alu_sltu = 4'd6;
  localparam logic [3:0] alu_sll  = 4'd7;
  localparam logic [3:0] alu_srl  = 4'd8;
  localparam logic [3:0] alu_sra  = 4'd9;

  // system func3
  localparam logic [3:0] sys_priv   = 4'd0;
  localparam logic [3:0] sys_csrrw  = 4'd1;
  localparam logic [3:0] sys_csrrs  = 4'd2;
  localparam logic [3:0] sys_csrrc  = 4'd3;
  localparam logic [3:0] sys_csrrwi = 4'd5;
  localparam logic [3:0] sys_csrrsi = 4'd6;
  localparam logic [3:0] sys_csrrci = 4'd7;

  localparam logic [11:0] f12_ecall  = 12'h000;
  localparam logic [11:0] f12_ebreak = 12'h001;
  localparam logic [11:0] f12_mret   = 12'h302;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam logic [xlen-1:0] cause_ecall_m = 11;

  typedef struct packed {
    logic [15:0] pad;
    logic [11:0] funct12;
    logic [3:0]  funct3;
  } sys_fields_t;

  // system ops read the sys view, all others the plain value
  typedef union packed {
    logic [xlen-1:0] val;
    sys_fields_t     sys;
  } imm_word_u;

endpackage

//--- hw/exu_top.sv
`timescale 1ns/1ns

module exu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic [6:0]               opcode_i,
  input  logic [3:0]               alu_op_i,
  input  logic [exu_pkg::xlen-1:0] op1_i,
  input  logic [exu_pkg::xlen-1:0] op2_i,
  input  logic [exu_pkg::xlen-1:0] op_j_i,
  input  logic [exu_pkg::xlen-1:0] pc_i,
  input  logic [4:0]               rd_i,
  input  logic [exu_pkg::xlen-1:0] imm_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [4:0]               rd_o,
  output logic [exu_pkg::xlen-1:0] reg_wdata_o,
  output logic [exu_pkg::xlen-1:0] npc_o,
  output logic                     use_npc_o,
  output logic                     ebreak_o,
  input  logic                     fetch_req_i,
  input  logic [exu_pkg::xlen-1:0] fetch_addr_i,
  output logic                     fetch_valid_o,
  output logic [exu_pkg::xlen-1:0] fetch_data_o
);

  exu_pkg::imm_word_u imm_w;

  assign imm_w = exu_pkg::imm_word_u'(imm_i);

  mem_bus_if lsu_bus ();
  mem_bus_if fetch_bus ();
  mem_bus_if ram_bus ();

  exu_core u_core (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .opcode_i    (opcode_i),
    .alu_op_i    (alu_op_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .op_j_i      (op_j_i),
    .pc_i        (pc_i),
    .rd_i        (rd_i),
    .imm_i       (imm_w),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .reg_wdata_o (reg_wdata_o),
    .npc_o       (npc_o),
    .use_npc_o   (use_npc_o),
    .ebreak_o    (ebreak_o),
    .lsu         (lsu_bus.requester)
  );

  fetch_port u_fetch (
    .clk     (clk),
    .rst     (rst),
    .req_i   (fetch_req_i),
    .addr_i  (fetch_addr_i),
    .valid_o (fetch_valid_o),
    .data_o  (fetch_data_o),
    .bus     (fetch_bus.requester)
  );

  mem_arbiter u_arb (
    .clk   (clk),
    .rst   (rst),
    .lsu   (lsu_bus.responder),
    .fetch (fetch_bus.responder),
    .ram   (ram_bus.requester)
  );

  data_ram u_ram (
    .clk (clk),
    .bus (ram_bus.responder)
  );

endmodule

//--- hw/fetch_port.sv
`timescale 1ns/1ns

module fetch_port (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_i,
  input  logic [exu_pkg::xlen-1:0] addr_i,
  output logic                     valid_o,
  output logic [exu_pkg::xlen-1:0] data_o,
  mem_bus_if.requester             bus
);

  logic                     pending_q;
  logic                     valid_q;
  logic [exu_pkg::xlen-1:0] addr_q;
  logic [exu_pkg::xlen-1:0] data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (bus.done) begin
        pending_q <= 1'b0;
        valid_q   <= 1'b1;
      end else if (req_i && !pending_q) begin
        pending_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_i && !pending_q) addr_q <= addr_i;
    if (bus.done) data_q <= bus.rdata;
  end

  // read only
  assign bus.req   = pending_q;
  assign bus.we    = 1'b0;
  assign bus.addr  = addr_q;
  assign bus.wdata = '0;

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
  input  logic         clk,
  input  logic         rst,
  mem_bus_if.responder lsu,
  mem_bus_if.responder fetch,
  mem_bus_if.requester ram
);

  logic locked_q;
  // 0 lsu, 1 fetch
  logic owner_q;
  logic grant_fetch;

  // lsu has priority when nobody holds the ram
  assign grant_fetch = locked_q ? owner_q : !lsu.req;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
    end else if (ram.done) begin
      locked_q <= 1'b0;
    end else if (!locked_q && ram.req) begin
      locked_q <= 1'b1;
      owner_q  <= grant_fetch;
    end
  end

  assign ram.req   = grant_fetch ? fetch.req   : lsu.req;
  assign ram.we    = grant_fetch ? fetch.we    : lsu.we;
  assign ram.addr  = grant_fetch ? fetch.addr  : lsu.addr;
  assign ram.wdata = grant_fetch ? fetch.wdata : lsu.wdata;

  // done goes to the owner only
  assign lsu.done   = ram.done && locked_q && !owner_q;
  assign fetch.done = ram.done && locked_q && owner_q;

  assign lsu.rdata   = ram.rdata;
  assign fetch.rdata = ram.rdata;

endmodule

//--- hw/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if;

  logic                     req;
  logic                     we;
  // word address
  logic [exu_pkg::xlen-1:0] addr;
  logic [exu_pkg::xlen-1:0] wdata;
  logic [exu_pkg::xlen-1:0] rdata;
  logic                     done;

  modport requester (
    output req, we, addr, wdata,
    input  rdata, done
  );

  modport responder (
    input  req, we, addr, wdata,
    output rdata, done
  );

endinterface

//--- project.f
hw/exu_pkg.sv
hw/mem_bus_if.sv
hw/exu_alu.sv
hw/exu_csr.sv
hw/exu_core.sv
hw/fetch_port.sv
hw/mem_arbiter.sv
hw/data_ram.sv
hw/exu_top.sv
verif/tb_exu_top.sv

//--- verif/tb_exu_top.sv
`timescale 1ns/1ns

module tb_exu_top;

  logic                     clk;
  logic                     rst;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic [6:0]               opcode_i;
  logic [3:0]               alu_op_i;
  logic [exu_pkg::xlen-1:0] op1_i;
  logic [exu_pkg::xlen-1:0] op2_i;
  logic [exu_pkg::xlen-1:0] op_j_i;
  logic [exu_pkg::xlen-1:0] pc_i;
  logic [4:0]               rd_i;
  logic [exu_pkg::xlen-1:0] imm_i;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic [4:0]               rd_o;
  logic [exu_pkg::xlen-1:0] reg_wdata_o;
  logic [exu_pkg::xlen-1:0] npc_o;
  logic                     use_npc_o;
  logic                     ebreak_o;
  logic                     fetch_req_i;
  logic [exu_pkg::xlen-1:0] fetch_addr_i;
  logic                     fetch_valid_o;
  logic [exu_pkg::xlen-1:0] fetch_data_o;

  int checks = 0;
  int errors = 0;
  int max_wait = 200;
  // reference copies of the CSRs
  logic [exu_pkg::xlen-1:0] mstatus_m;
  logic [exu_pkg::xlen-1:0] mtvec_m;

  exu_top dut0 (.*);

  always #5 clk = ~clk;

  task automatic check_word(input string name, input logic [exu_pkg::xlen-1:0] exp,
                            input logic [exu_pkg::xlen-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_rd(input logic [4:0] exp, input logic [4:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED at %0t: rd_o expected %0d, got %0d", $time, exp, act);
    end
  endtask

  function automatic logic [exu_pkg::xlen-1:0] sys_imm(input logic [11:0] f12,
                                                       input logic [3:0] f3);
    exu_pkg::imm_word_u w;
    w.val = '0;
    w.sys.funct12 = f12;
    w.sys.funct3 = f3;
    return w.val;
  endfunction

  function automatic logic [exu_pkg::xlen-1:0] alu_model(input logic [3:0] op,
      input logic [exu_pkg::xlen-1:0] a, input logic [exu_pkg::xlen-1:0] b);
    int unsigned sh;
    sh = b % 32;
    case (op)
      exu_pkg::alu_add:  return a + b;
      exu_pkg::alu_sub:  return a - b;
      exu_pkg::alu_and:  return a & b;
      exu_pkg::alu_or:   return a | b;
      exu_pkg::alu_xor:  return a ^ b;
      exu_pkg::alu_slt:  return (int'(a) < int'(b)) ? 1 : 0;
      exu_pkg::alu_sltu: return (a < b) ? 1 : 0;
      exu_pkg::alu_sll:  return a << sh;
      exu_pkg::alu_srl:  return a >> sh;
      exu_pkg::alu_sra:  return int'(a) >>> sh;
      default:           return 0;
    endcase
  endfunction

  // beq, bne, blt, bltu map to sub, xor, slt, sltu
  function automatic logic branch_model(input logic [3:0] op,
      input logic [exu_pkg::xlen-1:0] a, input logic [exu_pkg::xlen-1:0] b);
    case (op)
      exu_pkg::alu_sub:  return a == b;
      exu_pkg::alu_xor:  return a != b;
      exu_pkg::alu_slt:  return int'(a) < int'(b);
      default:           return a < b;
    endcase
  endfunction

  task automatic drive_op(input logic [6:0] opc, input logic [3:0] aop,
                          input logic [exu_pkg::xlen-1:0] a, input logic [exu_pkg::xlen-1:0] b,
                          input logic [exu_pkg::xlen-1:0] j, input logic [exu_pkg::xlen-1:0] pc,
                          input logic [exu_pkg::xlen-1:0] imm, input logic [4:0] rd);
    opcode_i = opc;
    alu_op_i = aop;
    op1_i    = a;
    op2_i    = b;
    op_j_i   = j;
    pc_i     = pc;
    imm_i    = imm;
    rd_i     = rd;
  endtask

  task automatic issue(input logic [6:0] opc, input logic [3:0] aop,
                       input logic [exu_pkg::xlen-1:0] a, input logic [exu_pkg::xlen-1:0] b,
                       input logic [exu_pkg::xlen-1:0] j, input logic [exu_pkg::xlen-1:0] pc,
                       input logic [exu_pkg::xlen-1:0] imm, input logic [4:0] rd);
    int n;
    @(negedge clk);
    drive_op(opc, aop, a, b, j, pc, imm, rd);
    in_valid_i = 1'b1;
    #1;
    n = 0;
    while (!in_ready_o && n < max_wait) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!in_ready_o) begin
      errors++;
      $display("timeout: the execute stage never accepted the operation");
    end
    @(negedge clk);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_result;
    int n;
    n = 0;
    #1;
    while (!out_valid_o && n < max_wait) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!out_valid_o) begin
      errors++;
      $display("timeout: no result came out of the execute stage");
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic csr_access(input logic [3:0] f3, input logic [11:0] addr,
                            input logic [exu_pkg::xlen-1:0] val,
                            input logic [exu_pkg::xlen-1:0] exp_old);
    issue(exu_pkg::op_system, exu_pkg::alu_add, val, 0, 0, 0, sys_imm(addr, f3), 5'd7);
    wait_result();
    check_word("reg_wdata_o", exp_old, reg_wdata_o);
    check_rd(5'd7, rd_o);
  endtask

  task automatic mem_op(input logic [6:0] opc, input logic [7:0] w,
                        input logic [exu_pkg::xlen-1:0] data);
    // word index split over op1 and the immediate
    issue(opc, exu_pkg::alu_add, {22'd0, w, 2'b00} - 32'd16, data, 0, 0, 32'd16, 5'd3);
    wait_result();
  endtask

  task automatic run_alu_test;
    logic [3:0] ops [10];
    logic [exu_pkg::xlen-1:0] a;
    logic [exu_pkg::xlen-1:0] b;
    logic [4:0] rd;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    ops = '{exu_pkg::alu_add, exu_pkg::alu_sub, exu_pkg::alu_and, exu_pkg::alu_or,
            exu_pkg::alu_xor, exu_pkg::alu_slt, exu_pkg::alu_sltu, exu_pkg::alu_sll,
            exu_pkg::alu_srl, exu_pkg::alu_sra};
    for (int k = 0; k < 10; k++) begin
      for (int i = 0; i < 20; i++) begin
        a = $urandom;
        b = $urandom;
        rd = $urandom % 32;
        issue(exu_pkg::op_alu, ops[k], a, b, 0, 0, 0, rd);
        wait_result();
        check_word("reg_wdata_o", alu_model(ops[k], a, b), reg_wdata_o);
        check_rd(rd, rd_o);
        check_bit("ebreak_o", 1'b0, ebreak_o);
      end
    end
    report_test("alu", c0, e0);
  endtask

  task automatic run_branch_test;
    logic [3:0] ops [4];
    logic [exu_pkg::xlen-1:0] lo;
    logic [exu_pkg::xlen-1:0] hi;
    logic [exu_pkg::xlen-1:0] a [3];
    logic [exu_pkg::xlen-1:0] b [3];
    logic [exu_pkg::xlen-1:0] j;
    logic [exu_pkg::xlen-1:0] imm;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    ops = '{exu_pkg::alu_sub, exu_pkg::alu_xor, exu_pkg::alu_slt, exu_pkg::alu_sltu};
    // negative and positive words cover taken and not taken for every kind
    lo = {1'b1, 31'($urandom)};
    hi = {1'b0, 31'($urandom)};
    a = '{hi, lo, hi};
    b = '{hi, hi, lo};
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 3; i++) begin
        j = $urandom & ~32'd3;
        imm = ($urandom % 4096) & ~32'd1;
        issue(exu_pkg::op_branch, ops[k], a[i], b[i], j, j, imm, 5'd0);
        wait_result();
        check_bit("use_npc_o", branch_model(ops[k], a[i], b[i]), use_npc_o);
        check_word("npc_o", j + imm, npc_o);
      end
    end
    j = $urandom & ~32'd3;
    imm = ($urandom % 4096) & ~32'd1;
    issue(exu_pkg::op_jal, exu_pkg::alu_add, 0, 0, j, j, imm, 5'd1);
    wait_result();
    check_bit("use_npc_o", 1'b1, use_npc_o);
    check_word("reg_wdata_o", j + 32'd4, reg_wdata_o);
    check_word("npc_o", j + imm, npc_o);
    report_test("branch and jump", c0, e0);
  endtask

  task automatic run_mem_test;
    logic [7:0] w;
    logic [exu_pkg::xlen-1:0] data;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    w = $urandom % exu_pkg::ram_words;
    data = $urandom;
    mem_op(exu_pkg::op_store, w, data);
    @(negedge clk);
    out_ready_i = 1'b0;
    mem_op(exu_pkg::op_load, w, 0);
    check_word("reg_wdata_o", data, reg_wdata_o);
    // result must hold while the consumer stalls
    repeat (5) begin
      @(negedge clk);
      #1;
      check_bit("out_valid_o", 1'b1, out_valid_o);
      check_word("reg_wdata_o", data, reg_wdata_o);
    end
    @(negedge clk);
    out_ready_i = 1'b1;
    @(negedge clk);
    #1;
    check_bit("out_valid_o", 1'b0, out_valid_o);
    report_test("memory", c0, e0);
  endtask

  task automatic run_csr_test;
    logic [exu_pkg::xlen-1:0] v;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    mtvec_m = $urandom & ~32'd3;
    csr_access(exu_pkg::sys_csrrw, exu_pkg::csr_mtvec, mtvec_m, 0);
    csr_access(exu_pkg::sys_csrrs, exu_pkg::csr_mtvec, 0, mtvec_m);
    v = $urandom;
    csr_access(exu_pkg::sys_csrrs, exu_pkg::csr_mstatus, v, mstatus_m);
    mstatus_m = mstatus_m | v;
    v = $urandom;
    csr_access(exu_pkg::sys_csrrc, exu_pkg::csr_mstatus, v, mstatus_m);
    mstatus_m = mstatus_m & ~v;
    csr_access(exu_pkg::sys_csrrsi, exu_pkg::csr_mstatus, 0, mstatus_m);
    report_test("csr", c0, e0);
  endtask

  task automatic run_system_test;
    logic [exu_pkg::xlen-1:0] pc_e;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    pc_e = $urandom & ~32'd3;
    issue(exu_pkg::op_system, exu_pkg::alu_add, 0, 0, 0, pc_e,
          sys_imm(exu_pkg::f12_ecall, exu_pkg::sys_priv), 5'd0);
    wait_result();
    check_bit("use_npc_o", 1'b1, use_npc_o);
    check_word("npc_o", mtvec_m, npc_o);
    check_bit("ebreak_o", 1'b0, ebreak_o);
    csr_access(exu_pkg::sys_csrrs, exu_pkg::csr_mcause, 0, 32'd11);
    issue(exu_pkg::op_system, exu_pkg::alu_add, 0, 0, 0, 0,
          sys_imm(exu_pkg::f12_mret, exu_pkg::sys_priv), 5'd0);
    wait_result();
    check_bit("use_npc_o", 1'b1, use_npc_o);
    check_word("npc_o", pc_e, npc_o);
    // mpie goes to mie and mpie is set
    mstatus_m[3] = mstatus_m[7];
    mstatus_m[7] = 1'b1;
    csr_access(exu_pkg::sys_csrrs, exu_pkg::csr_mstatus, 0, mstatus_m);
    issue(exu_pkg::op_system, exu_pkg::alu_add, 0, 0, 0, 0,
          sys_imm(exu_pkg::f12_ebreak, exu_pkg::sys_priv), 5'd0);
    wait_result();
    check_bit("ebreak_o", 1'b1, ebreak_o);
    check_bit("use_npc_o", 1'b0, use_npc_o);
    report_test("system", c0, e0);
  endtask

  task automatic run_shared_test;
    logic [7:0] wa;
    logic [7:0] wb;
    logic [exu_pkg::xlen-1:0] da;
    logic [exu_pkg::xlen-1:0] db;
    logic [exu_pkg::xlen-1:0] load_val;
    logic [exu_pkg::xlen-1:0] fetch_val;
    logic got_load;
    logic got_fetch;
    int n;
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    wa = $urandom % exu_pkg::ram_words;
    wb = wa + 8'd1 + 8'($urandom % 200);
    da = $urandom;
    db = $urandom;
    mem_op(exu_pkg::op_store, wa, da);
    mem_op(exu_pkg::op_store, wb, db);
    @(negedge clk);
    drive_op(exu_pkg::op_load, exu_pkg::alu_add, {22'd0, wa, 2'b00}, 0, 0, 0, 0, 5'd4);
    in_valid_i = 1'b1;
    fetch_req_i = 1'b1;
    fetch_addr_i = {24'd0, wb};
    #1;
    if (!in_ready_o) begin
      errors++;
      $display("the load was not accepted in the same cycle as the fetch");
    end
    @(negedge clk);
    in_valid_i = 1'b0;
    fetch_req_i = 1'b0;
    got_load = 1'b0;
    got_fetch = 1'b0;
    n = 0;
    while (!(got_load && got_fetch) && n < max_wait) begin
      #1;
      if (out_valid_o && !got_load) begin
        got_load = 1'b1;
        load_val = reg_wdata_o;
      end
      if (fetch_valid_o) begin
        got_fetch = 1'b1;
        fetch_val = fetch_data_o;
      end
      @(negedge clk);
      n++;
    end
    if (!got_load || !got_fetch) begin
      errors++;
      $display("timeout: the load or the fetch never completed");
    end
    check_word("reg_wdata_o", da, load_val);
    check_word("fetch_data_o", db, fetch_val);
    report_test("shared ram", c0, e0);
  endtask

  initial begin
    void'($urandom(43124));
    clk = 1'b0;
    rst = 1'b1;
    in_valid_i = 1'b0;
    out_ready_i = 1'b1;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    drive_op(exu_pkg::op_alu, exu_pkg::alu_add, 0, 0, 0, 0, 0, 5'd0);
    mstatus_m = '0;
    mtvec_m = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    run_alu_test();
    run_branch_test();
    run_mem_test();
    run_csr_test();
    run_system_test();
    run_shared_test();
    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
